/* Bender.yml */
package:
  name: ooo_core

sources:
  - ooo_pkg.sv
  - rob.sv
  - alu_unit.sv
  - load_unit.sv
  - result_arbiter.sv
  - ooo_core.sv
  - target: test
    files:
      - tb_ooo_core.sv

/* alu_unit.sv */
`timescale 1ns/10ps

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              alu_issue,
    input  ooo_pkg::op_t      alu_op,
    input  ooo_pkg::word_t    alu_a,
    input  ooo_pkg::word_t    alu_b,
    input  ooo_pkg::rob_tag_t alu_tag,
    input  logic              alu_grant,
    output logic              alu_accept,
    output logic              alu_res_valid,
    output ooo_pkg::rob_tag_t alu_res_tag,
    output ooo_pkg::word_t    alu_res_value
);

    ooo_pkg::word_t result;

    always_comb begin
        case (alu_op)
            ooo_pkg::OP_ADD: result = alu_a + alu_b;
            ooo_pkg::OP_SUB: result = alu_a - alu_b;
            ooo_pkg::OP_AND: result = alu_a & alu_b;
            ooo_pkg::OP_XOR: result = alu_a ^ alu_b;
            default:         result = alu_b;
        endcase
    end

    // Register is free when empty or draining this cycle.
    assign alu_accept = !alu_res_valid || alu_grant;

    always_ff @(posedge clk) begin
        if (!rst) begin
            alu_res_valid <= 1'b0;
        end else if (alu_issue) begin
            alu_res_valid <= 1'b1;
        end else if (alu_grant) begin
            alu_res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_res_tag   <= alu_tag;
            alu_res_value <= result;
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst) alu_issue |-> alu_accept);

endmodule

/* load_unit.sv */
`timescale 1ns/10ps

module load_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              ld_issue,
    input  ooo_pkg::word_t    ld_addr,
    input  ooo_pkg::rob_tag_t ld_tag,
    input  logic              ld_grant,
    input  ooo_pkg::word_t    wb_rdata,
    input  logic              wb_ack,
    output logic              ld_accept,
    output logic              ld_res_valid,
    output ooo_pkg::rob_tag_t ld_res_tag,
    output ooo_pkg::word_t    ld_res_value,
    output logic              wb_cyc,
    output logic              wb_stb,
    output ooo_pkg::word_t    wb_adr
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,   // Wishbone read in flight.
        HOLD   // Data waits for the result bus.
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (ld_issue) state <= BUS;
                BUS:     if (wb_ack) state <= HOLD;
                HOLD:    if (ld_grant) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && ld_issue) begin
            wb_adr     <= ld_addr;
            ld_res_tag <= ld_tag;
        end
        if (state == BUS && wb_ack) begin
            ld_res_value <= wb_rdata;  // Captured on the ack edge.
        end
    end

    assign ld_accept    = (state == IDLE);
    assign ld_res_valid = (state == HOLD);
    assign wb_cyc       = (state == BUS);
    assign wb_stb       = (state == BUS);

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc);

endmodule

/* ooo_core.sv */
`timescale 1ns/10ps

module ooo_core #(
    parameter int DEPTH = 7
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    input  ooo_pkg::op_t      disp_op,
    input  ooo_pkg::reg_idx_t disp_rd,
    input  ooo_pkg::word_t    disp_a,
    input  ooo_pkg::word_t    disp_b,
    output logic              disp_ready,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::word_t    commit_value,
    output ooo_pkg::rob_tag_t commit_tag,
    output logic              wb_cyc,
    output logic              wb_stb,
    output ooo_pkg::word_t    wb_adr,
    input  ooo_pkg::word_t    wb_rdata,
    input  logic              wb_ack
);

    // ============================
    // Issue paths
    // ============================

    logic              alu_issue;
    ooo_pkg::op_t      alu_op;
    ooo_pkg::word_t    alu_a;
    ooo_pkg::word_t    alu_b;
    ooo_pkg::rob_tag_t alu_tag;
    logic              alu_accept;
    logic              ld_issue;
    ooo_pkg::word_t    ld_addr;
    ooo_pkg::rob_tag_t ld_tag;
    logic              ld_accept;

    // ============================
    // Result paths
    // ============================

    logic              alu_res_valid;
    ooo_pkg::rob_tag_t alu_res_tag;
    ooo_pkg::word_t    alu_res_value;
    logic              alu_grant;
    logic              ld_res_valid;
    ooo_pkg::rob_tag_t ld_res_tag;
    ooo_pkg::word_t    ld_res_value;
    logic              ld_grant;
    logic              res_valid;
    ooo_pkg::rob_tag_t res_tag;
    ooo_pkg::word_t    res_value;

    rob #(
        .DEPTH(DEPTH)
    ) u_rob (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_op      (disp_op),
        .disp_rd      (disp_rd),
        .disp_a       (disp_a),
        .disp_b       (disp_b),
        .disp_ready   (disp_ready),
        .alu_issue    (alu_issue),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_tag      (alu_tag),
        .alu_accept   (alu_accept),
        .ld_issue     (ld_issue),
        .ld_addr      (ld_addr),
        .ld_tag       (ld_tag),
        .ld_accept    (ld_accept),
        .res_valid    (res_valid),
        .res_tag      (res_tag),
        .res_value    (res_value),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_tag   (commit_tag)
    );

    alu_unit u_alu_unit (
        .clk           (clk),
        .rst           (rst),
        .alu_issue     (alu_issue),
        .alu_op        (alu_op),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_tag       (alu_tag),
        .alu_grant     (alu_grant),
        .alu_accept    (alu_accept),
        .alu_res_valid (alu_res_valid),
        .alu_res_tag   (alu_res_tag),
        .alu_res_value (alu_res_value)
    );

    load_unit u_load_unit (
        .clk          (clk),
        .rst          (rst),
        .ld_issue     (ld_issue),
        .ld_addr      (ld_addr),
        .ld_tag       (ld_tag),
        .ld_grant     (ld_grant),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .ld_accept    (ld_accept),
        .ld_res_valid (ld_res_valid),
        .ld_res_tag   (ld_res_tag),
        .ld_res_value (ld_res_value),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr)
    );

    result_arbiter u_result_arbiter (
        .alu_res_valid (alu_res_valid),
        .alu_res_tag   (alu_res_tag),
        .alu_res_value (alu_res_value),
        .ld_res_valid  (ld_res_valid),
        .ld_res_tag    (ld_res_tag),
        .ld_res_value  (ld_res_value),
        .alu_grant     (alu_grant),
        .ld_grant      (ld_grant),
        .res_valid     (res_valid),
        .res_tag       (res_tag),
        .res_value     (res_value)
    );

endmodule

/* ooo_pkg.sv */
package ooo_pkg;

    // ============================
    // Widths
    // ============================

    typedef logic [31:0] word_t;     // Data or address word.
    typedef logic [4:0]  reg_idx_t;  // Architectural destination register.
    typedef logic [2:0]  rob_tag_t;  // Reorder buffer tag.

    localparam rob_tag_t TAG_NONE  = 3'd0;  // Reserved, marks no entry.
    localparam rob_tag_t FIRST_TAG = 3'd1;

    // ============================
    // Operations
    // ============================

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LUI = 3'd4,  // Value is b, done at dispatch.
        OP_LW  = 3'd5   // Word load from a + b.
    } op_t;

    function automatic logic is_load(op_t op);
        return op == OP_LW;
    endfunction

    function automatic logic is_alu(op_t op);
        logic hit;
        case (op)
            OP_ADD,
            OP_SUB,
            OP_AND,
            OP_XOR:  hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

/* ooo_testdata.txt */
# op rd a b expected, all hex, one dispatch per line
# op: 0 add, 1 sub, 2 and, 3 xor, 4 lui, 5 lw (data at x is x ^ 5a5a0000)
0 01 00000011 00000022 00000033
1 02 00000100 00000001 000000ff
2 03 ff00ff00 0f0f0f0f 0f000f00
3 04 aaaa5555 ffff0000 55555555
4 05 00000000 12345000 12345000
5 06 00001000 00000010 5a5a1010
0 07 00000005 00000007 0000000c
1 08 00000010 00000020 fffffff0
0 00 00000001 00000001 00000002
5 09 80000000 00000004 da5a0004
3 0a 12345678 87654321 95511559
4 00 00000000 deadb000 deadb000
5 0b 0000fff0 00000020 5a5b0010
5 0c 00002000 00000000 5a5a2000
0 0d ffffffff 00000001 00000000
2 0e 0000ffff 00ff00ff 000000ff
5 0f 5a5a0000 00000008 00000008
1 10 00000000 00000001 ffffffff
4 11 00000000 cafe0000 cafe0000
5 1f 00000100 00000300 5a5a0400

/* result_arbiter.sv */
`timescale 1ns/10ps

module result_arbiter (
    input  logic              alu_res_valid,
    input  ooo_pkg::rob_tag_t alu_res_tag,
    input  ooo_pkg::word_t    alu_res_value,
    input  logic              ld_res_valid,
    input  ooo_pkg::rob_tag_t ld_res_tag,
    input  ooo_pkg::word_t    ld_res_value,
    output logic              alu_grant,
    output logic              ld_grant,
    output logic              res_valid,
    output ooo_pkg::rob_tag_t res_tag,
    output ooo_pkg::word_t    res_value
);

    // Loads win, since the load unit stalls the bus while it holds.
    assign ld_grant  = ld_res_valid;
    assign alu_grant = alu_res_valid && !ld_res_valid;

    assign res_valid = ld_grant || alu_grant;
    assign res_value = ld_grant ? ld_res_value : alu_res_value;

    always_comb begin
        if (ld_grant) begin
            res_tag = ld_res_tag;
        end else if (alu_grant) begin
            res_tag = alu_res_tag;
        end else begin
            res_tag = ooo_pkg::TAG_NONE;
        end
    end

    always_comb begin
        a_one_grant: assert final (!(alu_grant && ld_grant));
    end

endmodule

/* rob.sv */
`timescale 1ns/10ps

module rob #(
    parameter int DEPTH = 7
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    input  ooo_pkg::op_t      disp_op,
    input  ooo_pkg::reg_idx_t disp_rd,
    input  ooo_pkg::word_t    disp_a,
    input  ooo_pkg::word_t    disp_b,
    output logic              disp_ready,
    output logic              alu_issue,
    output ooo_pkg::op_t      alu_op,
    output ooo_pkg::word_t    alu_a,
    output ooo_pkg::word_t    alu_b,
    output ooo_pkg::rob_tag_t alu_tag,
    input  logic              alu_accept,
    output logic              ld_issue,
    output ooo_pkg::word_t    ld_addr,
    output ooo_pkg::rob_tag_t ld_tag,
    input  logic              ld_accept,
    input  logic              res_valid,
    input  ooo_pkg::rob_tag_t res_tag,
    input  ooo_pkg::word_t    res_value,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::word_t    commit_value,
    output ooo_pkg::rob_tag_t commit_tag
);

    localparam ooo_pkg::rob_tag_t LAST_TAG   = ooo_pkg::rob_tag_t'(DEPTH);
    localparam logic [3:0]        FULL_COUNT = 4'(DEPTH);

    if (DEPTH < 2 || DEPTH > 7) begin : g_depth_check
        $error("rob DEPTH must lie in 2..7");
    end

    ooo_pkg::rob_tag_t head;
    ooo_pkg::rob_tag_t tail;
    logic [3:0]        count;     // Occupied entries.
    logic [DEPTH:1]    busy;
    logic [DEPTH:1]    done;
    ooo_pkg::reg_idx_t rd_q [1:DEPTH];
    ooo_pkg::word_t    value_q [1:DEPTH];

    logic unit_ready;
    logic disp_fire;
    logic retire;

    // Tags run 1..DEPTH and skip the reserved zero.
    function automatic ooo_pkg::rob_tag_t next_tag(ooo_pkg::rob_tag_t t);
        return (t == LAST_TAG) ? ooo_pkg::FIRST_TAG : t + 3'd1;
    endfunction

    // ============================
    // Dispatch and issue
    // ============================

    always_comb begin
        if (ooo_pkg::is_load(disp_op)) begin
            unit_ready = ld_accept;
        end else if (ooo_pkg::is_alu(disp_op)) begin
            unit_ready = alu_accept;
        end else begin
            unit_ready = 1'b1;  // lui needs no unit.
        end
    end

    assign disp_ready = (count != FULL_COUNT) && unit_ready;
    assign disp_fire  = disp_valid && disp_ready;

    assign alu_issue = disp_fire && ooo_pkg::is_alu(disp_op);
    assign alu_op    = disp_op;
    assign alu_a     = disp_a;
    assign alu_b     = disp_b;
    assign alu_tag   = tail;

    assign ld_issue = disp_fire && ooo_pkg::is_load(disp_op);
    assign ld_addr  = disp_a + disp_b;
    assign ld_tag   = tail;

    assign retire = busy[head] && done[head];

    // ============================
    // Entry state
    // ============================

    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= ooo_pkg::FIRST_TAG;
            tail         <= ooo_pkg::FIRST_TAG;
            count        <= '0;
            busy         <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (res_valid) begin
                done[res_tag] <= 1'b1;
            end
            if (disp_fire) begin
                busy[tail] <= 1'b1;
                done[tail] <= (disp_op == ooo_pkg::OP_LUI);
                tail       <= next_tag(tail);
            end
            // Writes to rd 0 leave the entry without a commit pulse.
            commit_valid <= retire && (rd_q[head] != '0);
            if (retire) begin
                busy[head] <= 1'b0;
                head       <= next_tag(head);
            end
            case ({disp_fire, retire})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            rd_q[tail]    <= disp_rd;
            value_q[tail] <= disp_b;  // Final value for lui.
        end
        if (res_valid) begin
            value_q[res_tag] <= res_value;
        end
        if (retire) begin
            commit_rd    <= rd_q[head];
            commit_value <= value_q[head];
            commit_tag   <= head;
        end
    end

    // A unit only reports tags that are still waiting.
    a_res_busy: assert property (@(posedge clk) disable iff (!rst)
        res_valid |-> (res_tag != ooo_pkg::TAG_NONE) && busy[res_tag] && !done[res_tag]);

    a_count: assert property (@(posedge clk) disable iff (!rst) count <= FULL_COUNT);

endmodule

/* src.f */
ooo_pkg.sv
rob.sv
alu_unit.sv
load_unit.sv
result_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

/* tb_ooo_core.sv */
`timescale 1ns/10ps

module tb_ooo_core;

    localparam int          DEPTH   = 7;
    localparam int          TIMEOUT = 2000;  // Cycles per wait loop.
    localparam logic [31:0] SEED    = 32'h6cf303a6;

    logic              clk;
    logic              rst;
    logic              disp_valid;
    ooo_pkg::op_t      disp_op;
    ooo_pkg::reg_idx_t disp_rd;
    ooo_pkg::word_t    disp_a;
    ooo_pkg::word_t    disp_b;
    logic              disp_ready;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::word_t    commit_value;
    ooo_pkg::rob_tag_t commit_tag;
    logic              wb_cyc;
    logic              wb_stb;
    ooo_pkg::word_t    wb_adr;
    ooo_pkg::word_t    wb_rdata;
    logic              wb_ack;

    ooo_pkg::op_t      row_op [$];
    ooo_pkg::reg_idx_t row_rd [$];
    ooo_pkg::word_t    row_a [$];
    ooo_pkg::word_t    row_b [$];
    ooo_pkg::word_t    row_exp [$];
    ooo_pkg::reg_idx_t exp_rd_q [$];
    ooo_pkg::word_t    exp_val_q [$];
    ooo_pkg::rob_tag_t exp_tag_q [$];
    logic              exp_load_q [$];

    logic [31:0]    rng;
    ooo_pkg::word_t cur_exp;    // Expected value of the row on the dispatch port.
    int             tag_next;   // Tag the next dispatch should receive.
    logic           burst;
    logic           saw_stall;
    logic           timed_out;
    logic           in_req;
    int             wait_left;
    int             checks;
    int             errors;
    int             alu_commits;
    int             load_commits;
    int             err_mark;

    ooo_core #(
        .DEPTH(DEPTH)
    ) u_ooo_core (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_op      (disp_op),
        .disp_rd      (disp_rd),
        .disp_a       (disp_a),
        .disp_b       (disp_b),
        .disp_ready   (disp_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_tag   (commit_tag),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack)
    );

    always #4 clk = ~clk;

    // ============================
    // Reference rules
    // ============================

    function automatic ooo_pkg::word_t mem_word(ooo_pkg::word_t addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            rng = lfsr_step(rng);
            v   = (v << 1) | rng[0];
        end
    endtask

    // ============================
    // Wishbone slave
    // ============================

    always @(posedge clk) begin
        if (!rst) begin
            in_req = 1'b0;
        end else if (wb_stb && wb_ack) begin
            in_req = 1'b0;  // Data taken on this edge.
            #1 wb_ack = 1'b0;
        end else if (wb_stb) begin
            if (!in_req) begin
                in_req = 1'b1;
                if (burst) wait_left = 7;
                else draw_bits(3, wait_left);
            end
            if (wait_left == 0) begin
                #1;
                wb_rdata = mem_word(wb_adr);
                wb_ack   = 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // ============================
    // Commit checker
    // ============================

    always @(posedge clk) begin : watch_commits
        ooo_pkg::reg_idx_t want_rd;
        ooo_pkg::word_t    want_val;
        ooo_pkg::rob_tag_t want_tag;
        logic              want_load;
        if (rst && commit_valid) begin
            checks++;
            assert (exp_rd_q.size() != 0) else begin
                $display("[FAIL] %0t: commit of rd %0d with nothing outstanding", $time, commit_rd);
                errors++;
            end
            if (exp_rd_q.size() != 0) begin
                want_rd   = exp_rd_q.pop_front();
                want_val  = exp_val_q.pop_front();
                want_tag  = exp_tag_q.pop_front();
                want_load = exp_load_q.pop_front();
                checks++;
                assert (commit_rd == want_rd && commit_value == want_val &&
                        commit_tag == want_tag) else begin
                    $display("[FAIL] %0t: got rd %0d val %h tag %0d, want rd %0d val %h tag %0d",
                             $time, commit_rd, commit_value, commit_tag,
                             want_rd, want_val, want_tag);
                    errors++;
                end
                if (want_load) load_commits++;
                else alu_commits++;
            end
        end
        if (rst && disp_valid && disp_ready) begin
            if (disp_rd != '0) begin  // rd 0 retires without a pulse.
                exp_rd_q.push_back(disp_rd);
                exp_val_q.push_back(cur_exp);
                exp_tag_q.push_back(ooo_pkg::rob_tag_t'(tag_next));
                exp_load_q.push_back(ooo_pkg::is_load(disp_op));
            end
            tag_next = (tag_next == DEPTH) ? 1 : tag_next + 1;  // Tags wrap back to 1.
            if (burst) begin
                checks++;
                assert (exp_rd_q.size() <= DEPTH) else begin
                    $display("[FAIL] %0t: %0d entries in flight, limit %0d", $time,
                             exp_rd_q.size(), DEPTH);
                    errors++;
                end
            end
        end else if (rst && disp_valid && burst && exp_rd_q.size() == DEPTH) begin
            saw_stall = 1'b1;
        end
    end

    // ============================
    // Stimulus
    // ============================

    task automatic load_rows();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_rd;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_exp;
        fd = $fopen("ooo_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open ooo_testdata.txt.");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", f_op, f_rd, f_a, f_b, f_exp);
                    if (n == 5) begin
                        row_op.push_back(ooo_pkg::op_t'(f_op[2:0]));
                        row_rd.push_back(f_rd[4:0]);
                        row_a.push_back(f_a);
                        row_b.push_back(f_b);
                        row_exp.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic dispatch_row(input int i);
        int   gap;
        int   waited;
        logic taken;
        gap = 0;
        if (!burst) draw_bits(2, gap);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        disp_valid = 1'b1;
        disp_op    = row_op[i];
        disp_rd    = row_rd[i];
        disp_a     = row_a[i];
        disp_b     = row_b[i];
        cur_exp    = row_exp[i];
        taken      = 1'b0;
        waited     = 0;
        while (!taken && waited < TIMEOUT) begin
            @(posedge clk);
            taken = disp_ready;
            waited++;
            #1;
        end
        disp_valid = 1'b0;
        if (!taken) begin
            $display("Timeout: row %0d was never accepted for dispatch.", i);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_pass(input logic long_burst);
        int waited;
        burst = long_burst;
        if (long_burst) begin
            // Loads first, so the ALU and lui rows pile up behind the last slow load.
            // rd 0 rows stay out, so the queue holds every entry in flight.
            for (int i = 0; i < row_op.size() && !timed_out; i++) begin
                if (row_rd[i] != '0 && ooo_pkg::is_load(row_op[i])) dispatch_row(i);
            end
            for (int i = 0; i < row_op.size() && !timed_out; i++) begin
                if (row_rd[i] != '0 && !ooo_pkg::is_load(row_op[i])) dispatch_row(i);
            end
        end else begin
            for (int i = 0; i < row_op.size() && !timed_out; i++) begin
                dispatch_row(i);
            end
        end
        waited = 0;
        while (!timed_out && exp_rd_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!timed_out && exp_rd_q.size() != 0) begin
            $display("Timeout: %0d dispatched entries never committed.", exp_rd_q.size());
            errors++;
            timed_out = 1'b1;
        end
        burst = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        disp_valid = 1'b0;
        disp_op    = ooo_pkg::OP_ADD;
        disp_rd    = '0;
        disp_a     = '0;
        disp_b     = '0;
        wb_rdata   = '0;
        wb_ack     = 1'b0;
        rng        = SEED;
        cur_exp    = '0;
        tag_next   = 1;
        burst      = 1'b0;
        saw_stall  = 1'b0;
        timed_out  = 1'b0;
        in_req     = 1'b0;
        wait_left  = 0;
        checks     = 0;
        errors     = 0;
        load_rows();
        repeat (5) @(posedge clk);
        #1 rst = 1'b1;

        checks++;
        assert (!commit_valid && !wb_cyc && !wb_stb && disp_ready) else begin
            $display("[FAIL] %0t: after reset commit_valid %b wb_cyc %b wb_stb %b disp_ready %b",
                     $time, commit_valid, wb_cyc, wb_stb, disp_ready);
            errors++;
        end
        $display("test reset: %0d errors", errors);

        alu_commits  = 0;
        load_commits = 0;
        err_mark     = errors;
        if (row_op.size() == 0) begin
            $display("No rows were read from ooo_testdata.txt.");
            errors++;
        end
        run_pass(1'b0);
        $display("test values and order: %0d alu/lui and %0d load commits, %0d errors",
                 alu_commits, load_commits, errors - err_mark);

        if (!timed_out) begin
            err_mark = errors;
            run_pass(1'b1);
            checks++;
            assert (saw_stall) else begin
                $display("disp_ready never went low with the buffer full during the burst.");
                errors++;
            end
            $display("test back-pressure: %0d errors", errors - err_mark);
        end

        $display("tests done, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
